//--- include/cpu_settings.svh
// CPU width and depth settings
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and instruction word
`define CPU_DATA_W 16

// Register file
`define CPU_REG_SEL_W 3
`define CPU_NUM_REGS 8

// Word address widths of instruction and data memories
`define CPU_IMEM_AW 8
`define CPU_DMEM_AW 8

// Opcode field in instr[15:11]
`define CPU_OPCODE_W 5

`endif

//--- rtl/cpu_pkg.sv
// CPU pipeline types
`include "cpu_settings.svh"

package cpu_pkg;

	typedef enum logic [`CPU_OPCODE_W-1:0] {
		OP_HALT = 5'b00000,
		OP_NOP  = 5'b00001,
		OP_ADDI = 5'b01000,
		OP_BEQZ = 5'b01100,
		OP_BNEZ = 5'b01101,
		OP_ST   = 5'b10000,
		OP_LD   = 5'b10001,
		OP_LBI  = 5'b11000,
		OP_ALU  = 5'b11011
	} opcode_e;

	// Matches the R-type funct field
	typedef enum logic [1:0] {
		ALU_ADD  = 2'b00,
		ALU_SUB  = 2'b01,
		ALU_XOR  = 2'b10,
		ALU_ANDN = 2'b11
	} alu_op_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    use_imm;
		logic    is_lbi;
		logic    is_halt;
		alu_op_e alu_op;
	} ctrl_t;

	// All-zero is a bubble since a real fetch never has pc2 of zero
	typedef struct packed {
		logic [`CPU_DATA_W-1:0] instr;
		logic [`CPU_DATA_W-1:0] pc2;
	} if_id_t;

	typedef struct packed {
		ctrl_t                     ctrl;
		logic [`CPU_DATA_W-1:0]    rs_val;
		logic [`CPU_DATA_W-1:0]    rt_val;
		logic [`CPU_REG_SEL_W-1:0] rs_sel;
		logic [`CPU_REG_SEL_W-1:0] rt_sel;
		logic [`CPU_REG_SEL_W-1:0] dst_sel;
		logic [7:0]                imm8;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                     ctrl;
		logic [`CPU_DATA_W-1:0]    result;
		logic [`CPU_DATA_W-1:0]    st_data;
		logic [`CPU_REG_SEL_W-1:0] dst_sel;
	} ex_mem_t;

	typedef struct packed {
		logic                      reg_write;
		logic                      is_halt;
		logic [`CPU_REG_SEL_W-1:0] dst_sel;
		logic [`CPU_DATA_W-1:0]    result;
	} mem_wb_t;

endpackage

//--- rtl/hazard_if.sv
// Forwarding and hazard interface
`timescale 1ns/1ns
`include "cpu_settings.svh"

interface hazard_if;

	// One slot per later stage with the youngest first
	logic                      ex_wr;
	logic [`CPU_REG_SEL_W-1:0] ex_sel;
	logic [`CPU_DATA_W-1:0]    ex_data;
	logic                      ex_load;

	logic                      mem_wr;
	logic [`CPU_REG_SEL_W-1:0] mem_sel;
	logic [`CPU_DATA_W-1:0]    mem_data;

	logic                      wb_wr;
	logic [`CPU_REG_SEL_W-1:0] wb_sel;
	logic [`CPU_DATA_W-1:0]    wb_data;

	modport decode (
		input ex_wr, ex_sel, ex_data, ex_load,
		input mem_wr, mem_sel, mem_data,
		input wb_wr, wb_sel, wb_data
	);

	// Execute publishes its own slot and forwards from the older ones
	modport execute (
		output ex_wr, ex_sel, ex_data, ex_load,
		input  mem_wr, mem_sel, mem_data,
		input  wb_wr, wb_sel, wb_data
	);

endinterface

//--- rtl/stage_reg.sv
// Pipeline stage register
`timescale 1ns/1ns

module stage_reg #(
	parameter type payload_t = cpu_pkg::if_id_t
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     en,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	// Zero payload carries no active control bit
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (en) begin
			if (bubble) begin
				q <= '0;
			end else begin
				q <= d;
			end
		end
	end

endmodule

//--- rtl/fetch_stage.sv
// Instruction fetch stage
`timescale 1ns/1ns
`include "cpu_settings.svh"

module fetch_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  logic                    load_en,
	input  logic [`CPU_IMEM_AW-1:0] load_addr,
	input  logic [`CPU_DATA_W-1:0]  load_data,
	input  logic                    hold,
	input  logic                    branch_taken,
	input  logic [`CPU_DATA_W-1:0]  branch_target,
	input  logic                    halt_seen,
	output cpu_pkg::if_id_t         out
);

	logic [`CPU_DATA_W-1:0] imem [2**`CPU_IMEM_AW];
	logic [`CPU_DATA_W-1:0] pc;
	logic [`CPU_DATA_W-1:0] pc2;
	logic                   running;

	// Program load port for use while idle
	always_ff @(posedge clk) begin
		if (load_en) begin
			imem[load_addr] <= load_data;
		end
	end

	assign pc2 = pc + `CPU_DATA_W'(2);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			running <= 1'b0;
			pc      <= '0;
		end else if (!running) begin
			if (start) begin
				running <= 1'b1;
				pc      <= '0;
			end
		end else if (halt_seen) begin
			running <= 1'b0;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else if (!hold) begin
			pc <= pc2;
		end
	end

	// Byte PC indexes word-wide memory
	always_comb begin
		if (running && !halt_seen) begin
			out.instr = imem[pc[`CPU_IMEM_AW:1]];
			out.pc2   = pc2;
		end else begin
			out = '0;
		end
	end

endmodule

//--- rtl/decode_stage.sv
// Instruction decode stage
`timescale 1ns/1ns
`include "cpu_settings.svh"

module decode_stage (
	input  logic                   clk,
	input  logic                   arst_n,
	input  cpu_pkg::if_id_t        in,
	hazard_if.decode               fwd,
	output cpu_pkg::id_ex_t        out,
	output logic                   stall,
	output logic                   branch_taken,
	output logic [`CPU_DATA_W-1:0] branch_target,
	output logic                   halt_seen
);

	import cpu_pkg::*;

	logic [`CPU_DATA_W-1:0]    regs [`CPU_NUM_REGS];
	logic                      valid;
	opcode_e                   opcode;
	ctrl_t                     ctrl;
	logic [`CPU_REG_SEL_W-1:0] rs_sel;
	logic [`CPU_REG_SEL_W-1:0] rt_sel;
	logic [`CPU_REG_SEL_W-1:0] dst_sel;
	logic                      rs_used;
	logic                      rt_used;
	logic                      is_beqz;
	logic                      is_bnez;
	logic [`CPU_DATA_W-1:0]    rs_val;
	logic [`CPU_DATA_W-1:0]    rt_val;
	logic [`CPU_DATA_W-1:0]    br_offset;

	assign valid  = |in.pc2;
	assign opcode = opcode_e'(in.instr[15:11]);
	assign rs_sel = in.instr[10:8];
	assign rt_sel = in.instr[7:5];

	always_comb begin
		ctrl    = '0;
		dst_sel = rt_sel;
		rs_used = 1'b0;
		rt_used = 1'b0;
		is_beqz = 1'b0;
		is_bnez = 1'b0;
		if (valid) begin
			case (opcode)
				OP_ALU: begin
					ctrl.reg_write = 1'b1;
					ctrl.alu_op    = alu_op_e'(in.instr[1:0]);
					dst_sel        = in.instr[4:2];
					rs_used        = 1'b1;
					rt_used        = 1'b1;
				end
				OP_ADDI: begin
					ctrl.reg_write = 1'b1;
					ctrl.use_imm   = 1'b1;
					ctrl.alu_op    = ALU_ADD;
					rs_used        = 1'b1;
				end
				OP_LBI: begin
					ctrl.reg_write = 1'b1;
					ctrl.is_lbi    = 1'b1;
					dst_sel        = rs_sel;
				end
				OP_ST: begin
					ctrl.mem_write = 1'b1;
					ctrl.use_imm   = 1'b1;
					rs_used        = 1'b1;
					rt_used        = 1'b1;
				end
				OP_LD: begin
					ctrl.reg_write = 1'b1;
					ctrl.mem_read  = 1'b1;
					ctrl.use_imm   = 1'b1;
					rs_used        = 1'b1;
				end
				OP_BEQZ: begin
					is_beqz = 1'b1;
					rs_used = 1'b1;
				end
				OP_BNEZ: begin
					is_bnez = 1'b1;
					rs_used = 1'b1;
				end
				OP_HALT: ctrl.is_halt = 1'b1;
				// NOP and unknown opcodes
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else if (fwd.wb_wr) begin
			regs[fwd.wb_sel] <= fwd.wb_data;
		end
	end

	// Youngest writer wins; the write-back term is the register file bypass
	always_comb begin
		if (fwd.ex_wr && fwd.ex_sel == rs_sel) begin
			rs_val = fwd.ex_data;
		end else if (fwd.mem_wr && fwd.mem_sel == rs_sel) begin
			rs_val = fwd.mem_data;
		end else if (fwd.wb_wr && fwd.wb_sel == rs_sel) begin
			rs_val = fwd.wb_data;
		end else begin
			rs_val = regs[rs_sel];
		end
	end

	always_comb begin
		if (fwd.ex_wr && fwd.ex_sel == rt_sel) begin
			rt_val = fwd.ex_data;
		end else if (fwd.mem_wr && fwd.mem_sel == rt_sel) begin
			rt_val = fwd.mem_data;
		end else if (fwd.wb_wr && fwd.wb_sel == rt_sel) begin
			rt_val = fwd.wb_data;
		end else begin
			rt_val = regs[rt_sel];
		end
	end

	// Load in execute has no data yet
	assign stall = fwd.ex_load &&
		((rs_used && fwd.ex_sel == rs_sel) || (rt_used && fwd.ex_sel == rt_sel));

	assign br_offset     = {{(`CPU_DATA_W-9){in.instr[7]}}, in.instr[7:0], 1'b0};
	assign branch_target = in.pc2 + br_offset;
	assign branch_taken  = !stall &&
		((is_beqz && rs_val == '0) || (is_bnez && rs_val != '0));
	assign halt_seen     = ctrl.is_halt;

	assign out = '{
		ctrl:    ctrl,
		rs_val:  rs_val,
		rt_val:  rt_val,
		rs_sel:  rs_sel,
		rt_sel:  rt_sel,
		dst_sel: dst_sel,
		imm8:    in.instr[7:0]
	};

endmodule

//--- rtl/execute_stage.sv
// Execute stage
`timescale 1ns/1ns
`include "cpu_settings.svh"

module execute_stage (
	input  cpu_pkg::id_ex_t  in,
	hazard_if.execute        fwd,
	output cpu_pkg::ex_mem_t out
);

	import cpu_pkg::*;

	logic [`CPU_DATA_W-1:0] op_a;
	logic [`CPU_DATA_W-1:0] rt_fwd;
	logic [`CPU_DATA_W-1:0] op_b;
	logic [`CPU_DATA_W-1:0] imm5_ext;
	logic [`CPU_DATA_W-1:0] imm8_ext;
	logic [`CPU_DATA_W-1:0] alu_out;
	logic [`CPU_DATA_W-1:0] result;

	// Memory result has priority over write-back
	always_comb begin
		if (fwd.mem_wr && fwd.mem_sel == in.rs_sel) begin
			op_a = fwd.mem_data;
		end else if (fwd.wb_wr && fwd.wb_sel == in.rs_sel) begin
			op_a = fwd.wb_data;
		end else begin
			op_a = in.rs_val;
		end
	end

	always_comb begin
		if (fwd.mem_wr && fwd.mem_sel == in.rt_sel) begin
			rt_fwd = fwd.mem_data;
		end else if (fwd.wb_wr && fwd.wb_sel == in.rt_sel) begin
			rt_fwd = fwd.wb_data;
		end else begin
			rt_fwd = in.rt_val;
		end
	end

	assign imm5_ext = {{(`CPU_DATA_W-5){in.imm8[4]}}, in.imm8[4:0]};
	assign imm8_ext = {{(`CPU_DATA_W-8){in.imm8[7]}}, in.imm8};
	assign op_b     = in.ctrl.use_imm ? imm5_ext : rt_fwd;

	always_comb begin
		case (in.ctrl.alu_op)
			ALU_SUB:  alu_out = op_a - op_b;
			ALU_XOR:  alu_out = op_a ^ op_b;
			ALU_ANDN: alu_out = op_a & ~op_b;
			default:  alu_out = op_a + op_b;
		endcase
	end

	// Loads and stores leave the address here
	assign result = in.ctrl.is_lbi ? imm8_ext : alu_out;

	assign out = '{
		ctrl:    in.ctrl,
		result:  result,
		st_data: rt_fwd,
		dst_sel: in.dst_sel
	};

	assign fwd.ex_wr   = in.ctrl.reg_write;
	assign fwd.ex_sel  = in.dst_sel;
	assign fwd.ex_data = result;
	assign fwd.ex_load = in.ctrl.mem_read;

endmodule

//--- rtl/memory_stage.sv
// Data memory stage
`timescale 1ns/1ns
`include "cpu_settings.svh"

module memory_stage (
	input  logic             clk,
	input  logic             arst_n,
	input  cpu_pkg::ex_mem_t in,
	output cpu_pkg::mem_wb_t out
);

	logic [`CPU_DATA_W-1:0]  dmem [2**`CPU_DMEM_AW];
	logic [`CPU_DMEM_AW-1:0] addr;

	// Word-aligned byte address
	assign addr = in.result[`CPU_DMEM_AW:1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dmem <= '{default: '0};
		end else if (in.ctrl.mem_write) begin
			dmem[addr] <= in.st_data;
		end
	end

	// Combinational read feeds the write-back result
	assign out = '{
		reg_write: in.ctrl.reg_write,
		is_halt:   in.ctrl.is_halt,
		dst_sel:   in.dst_sel,
		result:    in.ctrl.mem_read ? dmem[addr] : in.result
	};

endmodule

//--- rtl/cpu_top.sv
// Five-stage CPU top level
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      start,
	input  logic                      load_en,
	input  logic [`CPU_IMEM_AW-1:0]   load_addr,
	input  logic [`CPU_DATA_W-1:0]    load_data,
	output logic                      reg_wr_valid,
	output logic [`CPU_REG_SEL_W-1:0] reg_wr_sel,
	output logic [`CPU_DATA_W-1:0]    reg_wr_data,
	output logic                      halted
);

	import cpu_pkg::*;

	if_id_t                 fe_out;
	if_id_t                 de_in;
	id_ex_t                 de_out;
	id_ex_t                 ex_in;
	ex_mem_t                ex_out;
	ex_mem_t                me_in;
	mem_wb_t                me_out;
	mem_wb_t                wb_in;
	logic                   stall;
	logic                   branch_taken;
	logic [`CPU_DATA_W-1:0] branch_target;
	logic                   halt_seen;
	logic                   halt_flag;

	hazard_if haz ();

	fetch_stage u_fetch (
		.clk           (clk),
		.arst_n        (arst_n),
		.start         (start),
		.load_en       (load_en),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.hold          (stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.halt_seen     (halt_seen),
		.out           (fe_out)
	);

	// Wrong-path fetch is squashed on a taken branch
	stage_reg #(.payload_t(if_id_t)) u_if_id (
		.clk (clk), .arst_n (arst_n), .en (!stall), .bubble (branch_taken),
		.d   (fe_out), .q (de_in)
	);

	decode_stage u_decode (
		.clk           (clk),
		.arst_n        (arst_n),
		.in            (de_in),
		.fwd           (haz.decode),
		.out           (de_out),
		.stall         (stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.halt_seen     (halt_seen)
	);

	stage_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk (clk), .arst_n (arst_n), .en (1'b1), .bubble (stall),
		.d   (de_out), .q (ex_in)
	);

	execute_stage u_execute (
		.in  (ex_in),
		.fwd (haz.execute),
		.out (ex_out)
	);

	stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk (clk), .arst_n (arst_n), .en (1'b1), .bubble (1'b0),
		.d   (ex_out), .q (me_in)
	);

	memory_stage u_memory (
		.clk    (clk),
		.arst_n (arst_n),
		.in     (me_in),
		.out    (me_out)
	);

	stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk (clk), .arst_n (arst_n), .en (1'b1), .bubble (1'b0),
		.d   (me_out), .q (wb_in)
	);

	// Memory slot already carries loaded data
	assign haz.mem_wr   = me_out.reg_write;
	assign haz.mem_sel  = me_out.dst_sel;
	assign haz.mem_data = me_out.result;
	assign haz.wb_wr    = wb_in.reg_write;
	assign haz.wb_sel   = wb_in.dst_sel;
	assign haz.wb_data  = wb_in.result;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			halt_flag <= 1'b0;
		end else if (wb_in.is_halt) begin
			halt_flag <= 1'b1;
		end
	end

	assign reg_wr_valid = wb_in.reg_write;
	assign reg_wr_sel   = wb_in.dst_sel;
	assign reg_wr_data  = wb_in.result;
	assign halted       = halt_flag | wb_in.is_halt;

endmodule

//--- verif/cpu_chk.sv
// CPU output assertions
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_chk (
	input logic                      clk,
	input logic                      arst_n,
	input logic                      start,
	input logic                      reg_wr_valid,
	input logic [`CPU_REG_SEL_W-1:0] reg_wr_sel,
	input logic [`CPU_DATA_W-1:0]    reg_wr_data,
	input logic                      halted
);

	logic started;

	// Set by the first start pulse
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			started <= 1'b0;
		end else if (start) begin
			started <= 1'b1;
		end
	end

	halted_stays_high: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> halted)
		else $error("halted fell before reset");

	no_write_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
		halted |-> !reg_wr_valid)
		else $error("register write seen while halted");

	no_write_before_start: assert property (@(posedge clk) disable iff (!arst_n)
		!started |-> !reg_wr_valid)
		else $error("register write seen before start");

	outputs_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({reg_wr_valid, reg_wr_sel, reg_wr_data, halted}))
		else $error("unknown value on a top-level output");

endmodule

bind cpu_top cpu_chk u_chk (
	.clk          (clk),
	.arst_n       (arst_n),
	.start        (start),
	.reg_wr_valid (reg_wr_valid),
	.reg_wr_sel   (reg_wr_sel),
	.reg_wr_data  (reg_wr_data),
	.halted       (halted)
);

//--- verif/cpu_tb.sv
// CPU pipeline testbench
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_tb;

	logic                      clk;
	logic                      arst_n;
	logic                      start;
	logic                      load_en;
	logic [`CPU_IMEM_AW-1:0]   load_addr;
	logic [`CPU_DATA_W-1:0]    load_data;
	logic                      reg_wr_valid;
	logic [`CPU_REG_SEL_W-1:0] reg_wr_sel;
	logic [`CPU_DATA_W-1:0]    reg_wr_data;
	logic                      halted;

	// Program and expected writes from the golden file
	logic [`CPU_IMEM_AW-1:0]   prog_addr [$];
	logic [`CPU_DATA_W-1:0]    prog_word [$];
	logic [`CPU_REG_SEL_W-1:0] exp_sel [$];
	logic [`CPU_DATA_W-1:0]    exp_data [$];

	int errors = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int exp_idx = 0;

	cpu_top DUT (
		.clk          (clk),
		.arst_n       (arst_n),
		.start        (start),
		.load_en      (load_en),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.reg_wr_valid (reg_wr_valid),
		.reg_wr_sel   (reg_wr_sel),
		.reg_wr_data  (reg_wr_data),
		.halted       (halted)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	task automatic read_golden();
		int                     fd;
		int                     n;
		int                     lines;
		string                  line;
		logic [`CPU_DATA_W-1:0] a;
		logic [`CPU_DATA_W-1:0] b;
		lines = 0;
		fd = $fopen("verif/cpu_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file verif/cpu_golden.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 2) begin
					// Lines starting with anything else are comments
					if (line.getc(0) == "P") begin
						n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, b);
						prog_addr.push_back(a[`CPU_IMEM_AW-1:0]);
						prog_word.push_back(b);
						lines++;
					end else if (line.getc(0) == "E") begin
						n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, b);
						exp_sel.push_back(a[`CPU_REG_SEL_W-1:0]);
						exp_data.push_back(b);
						lines++;
					end
				end
			end
			$fclose(fd);
		end
		cycle_limit = 4 * lines + 40;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog_addr.size(); i++) begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_addr <= prog_addr[i];
			load_data <= prog_word[i];
		end
		@(posedge clk);
		load_en <= 1'b0;
	endtask

	task automatic check_write();
		assert (exp_idx < exp_sel.size())
		else begin
			errors++;
			$display("More register writes than expected at %0t", $time);
		end
		if (exp_idx < exp_sel.size()) begin
			assert (reg_wr_sel == exp_sel[exp_idx] && reg_wr_data == exp_data[exp_idx])
			else begin
				errors++;
				$display("Fail at %0t: write %0d went to r%0d with %h, expected r%0d with %h",
					$time, exp_idx, reg_wr_sel, reg_wr_data, exp_sel[exp_idx],
					exp_data[exp_idx]);
			end
			exp_idx++;
		end
	endtask

	task automatic finish_run();
		$display("Run complete with %0d errors, %0d of %0d writes checked",
			errors, exp_idx, exp_sel.size());
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	initial begin
		clk       = 1'b0;
		arst_n    = 1'b0;
		start     = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		read_golden();
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		load_program();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		// Writes are compared in program order until HALT retires
		while (!halted) begin
			@(negedge clk);
			if (reg_wr_valid) begin
				check_write();
			end
		end
		assert (exp_idx == exp_sel.size())
		else begin
			errors++;
			$display("Halted after only %0d of %0d expected writes", exp_idx, exp_sel.size());
		end
		repeat (4) begin
			@(negedge clk);
			assert (!reg_wr_valid && halted)
			else begin
				errors++;
				$display("Register write or drop of halted after HALT at %0t", $time);
			end
		end
		finish_run();
	end

	initial begin
		wait (cycle_limit > 0);
		wait (cycles >= cycle_limit);
		$display("Timeout after %0d cycles without the core halting", cycle_limit);
		errors++;
		finish_run();
	end

endmodule

//--- compile.f
+incdir+include
rtl/cpu_pkg.sv
rtl/hazard_if.sv
rtl/stage_reg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
verif/cpu_chk.sv
verif/cpu_tb.sv

//--- Makefile
TOP = cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ns -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then exit 1; fi
	@grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/cpu_golden.txt
# P  imem word address  instruction word (hex)
# E  register number  expected write value (hex) in write order
P 00 c105 LBI r1 5
P 01 c2fd LBI r2 -3
P 02 d94c ADD r3 r1 r2
P 03 d971 SUB r4 r1 r3
P 04 dc56 XOR r5 r4 r2
P 05 dd3b ANDN r6 r5 r1
P 06 46fa ADDI r7 r6 -6
P 07 400f ADDI r0 r0 15
P 08 81e3 ST r7 to r1+3
P 09 8943 LD r2 from r1+3
P 0a da0c ADD r3 r2 r0
P 0b 6301 BEQZ r3 untaken
P 0c db71 SUB r4 r3 r3
P 0d 6401 BEQZ r4 taken
P 0e c511 LBI r5 skipped
P 0f 6901 BNEZ r1 taken
P 10 c622 LBI r6 skipped
P 11 6c01 BNEZ r4 untaken
P 12 c57f LBI r5 127
P 13 dd18 ADD r6 r5 r0
P 14 0000 HALT
P 15 c733 LBI r7 never reached
E 1 0005
E 2 fffd
E 3 0002
E 4 0003
E 5 fffe
E 6 fffa
E 7 fff4
E 0 000f
E 2 fff4
E 3 0003
E 4 0000
E 5 007f
E 6 008e
